// ==== design/spi_pkg.sv ====
package spi_pkg;

  // ********************
  // frame bytes
  // ********************

  localparam int SPI_BYTE_W = 8;

  // command byte values, the first byte of every frame.
  typedef enum logic [SPI_BYTE_W-1:0] {
    OP_WRITE     = 8'h01,
    OP_READ      = 8'h02,
    OP_WRITE_INC = 8'h03,
    OP_STATUS    = 8'h05
  } spi_opcode_e;

  typedef enum logic [2:0] {
    ST_IDLE,    // waiting for a command byte.
    ST_ADDR,    // next parameter is the register address.
    ST_DATA,    // single write data byte.
    ST_STREAM,  // write data with address increment.
    ST_READ,    // read issued, dummy byte shifts the data out.
    ST_DRAIN    // remaining parameters are ignored.
  } dec_state_e;

endpackage

// ==== design/wb_pkg.sv ====
package wb_pkg;

  // ********************
  // internal bus
  // ********************

  localparam int WB_DATA_W = 8;

  // the master only waits for ack, so two states are enough.
  typedef enum logic {
    WB_IDLE,
    WB_BUS
  } wb_state_e;

endpackage

// ==== design/spi_slave_rx.sv ====
`timescale 1ns/1ps

module spi_slave_rx
  import spi_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  sck,
  input  logic                  mosi,
  input  logic                  ssel_n,
  input  logic [SPI_BYTE_W-1:0] reply_byte,
  output logic                  miso,
  output logic                  miso_en,
  output logic                  cmd_valid,
  output logic                  param_valid,
  output logic                  frame_start,
  output logic                  frame_end,
  output logic [SPI_BYTE_W-1:0] rx_byte
);

  localparam int CNT_W = $clog2(SPI_BYTE_W);

  logic                  sck_clr_n;
  logic [CNT_W-1:0]      bit_cnt;
  logic                  first_q;
  logic [SPI_BYTE_W-2:0] shift_q;
  logic [SPI_BYTE_W-1:0] hold_q;
  logic                  hold_first;
  logic                  byte_tgl;
  logic [2:0]            tgl_sync;
  logic [2:0]            ssel_sync;
  logic                  byte_done;

  // ********************
  // sck domain
  // ********************

  assign sck_clr_n = rst_n & ~ssel_n; // a deselect restarts the bit count.

  always_ff @(posedge sck or negedge sck_clr_n) begin
    if (!sck_clr_n) begin
      bit_cnt <= '0;
      first_q <= 1'b1;
    end else begin
      bit_cnt <= bit_cnt + 1'b1;
      if (bit_cnt == CNT_W'(SPI_BYTE_W - 1)) first_q <= 1'b0;
    end
  end

  // the completed byte is held for a whole byte time, long enough for the clk side.
  always_ff @(posedge sck) begin
    shift_q <= {shift_q[SPI_BYTE_W-3:0], mosi};
    if (bit_cnt == CNT_W'(SPI_BYTE_W - 1)) begin
      hold_q     <= {shift_q, mosi};
      hold_first <= first_q;
    end
  end

  always_ff @(posedge sck or negedge rst_n) begin
    if (!rst_n) begin
      byte_tgl <= 1'b0;
    end else if (!ssel_n && bit_cnt == CNT_W'(SPI_BYTE_W - 1)) begin
      byte_tgl <= ~byte_tgl;
    end
  end

  assign miso    = ssel_n ? 1'b0 : reply_byte[CNT_W'(SPI_BYTE_W - 1) - bit_cnt];
  assign miso_en = ~ssel_n;

  // ********************
  // clk domain
  // ********************

  assign byte_done = tgl_sync[2] ^ tgl_sync[1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tgl_sync    <= '0;
      ssel_sync   <= 3'b111; // deselected out of reset.
      cmd_valid   <= 1'b0;
      param_valid <= 1'b0;
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
    end else begin
      tgl_sync    <= {tgl_sync[1:0], byte_tgl};
      ssel_sync   <= {ssel_sync[1:0], ssel_n};
      cmd_valid   <= byte_done & hold_first;
      param_valid <= byte_done & ~hold_first;
      frame_start <= ssel_sync[2] & ~ssel_sync[1];
      frame_end   <= ~ssel_sync[2] & ssel_sync[1];
    end
  end

  always_ff @(posedge clk) begin
    if (byte_done) rx_byte <= hold_q; // stable while the strobe is high.
  end

endmodule

// ==== design/spi_cmd_decoder.sv ====
`timescale 1ns/1ps

module spi_cmd_decoder
  import spi_pkg::*;
#(
  parameter int ADDR_W = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_valid,
  input  logic                  param_valid,
  input  logic                  frame_start,
  input  logic                  frame_end,
  input  logic [SPI_BYTE_W-1:0] rx_byte,
  output logic                  req,
  output logic                  req_we,
  output logic                  bad_cmd,
  output logic                  status_req,
  output logic [ADDR_W-1:0]     req_addr,
  output logic [SPI_BYTE_W-1:0] req_wdata
);

  dec_state_e        state;
  spi_opcode_e       op_q;
  logic [ADDR_W-1:0] addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      op_q       <= OP_WRITE;
      addr_q     <= '0;
      req        <= 1'b0;
      req_we     <= 1'b0;
      bad_cmd    <= 1'b0;
      status_req <= 1'b0;
    end else begin
      req        <= 1'b0;
      bad_cmd    <= 1'b0;
      status_req <= 1'b0;
      if (frame_start || frame_end) begin
        state <= ST_IDLE;
      end else if (cmd_valid) begin
        op_q <= spi_opcode_e'(rx_byte);
        case (rx_byte)
          OP_WRITE, OP_READ, OP_WRITE_INC: state <= ST_ADDR;
          OP_STATUS: begin
            status_req <= 1'b1;
            state      <= ST_DRAIN;
          end
          default: begin
            bad_cmd <= 1'b1; // its parameters are swallowed in ST_DRAIN.
            state   <= ST_DRAIN;
          end
        endcase
      end else if (param_valid) begin
        case (state)
          ST_ADDR: begin
            addr_q <= rx_byte[ADDR_W-1:0];
            if (op_q == OP_READ) begin
              req    <= 1'b1;
              req_we <= 1'b0;
              state  <= ST_READ;
            end else begin
              state <= (op_q == OP_WRITE_INC) ? ST_STREAM : ST_DATA;
            end
          end
          ST_DATA: begin
            req    <= 1'b1;
            req_we <= 1'b1;
            state  <= ST_DRAIN;
          end
          ST_STREAM: begin
            req    <= 1'b1;
            req_we <= 1'b1;
            addr_q <= addr_q + 1'b1; // wraps at the top of the bank.
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (param_valid) begin
      req_addr  <= (state == ST_ADDR) ? rx_byte[ADDR_W-1:0] : addr_q;
      req_wdata <= rx_byte;
    end
  end

endmodule

// ==== design/wb_executor.sv ====
`timescale 1ns/1ps

module wb_executor
  import wb_pkg::*;
#(
  parameter int ADDR_W = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req,
  input  logic                 req_we,
  input  logic [ADDR_W-1:0]    req_addr,
  input  logic [WB_DATA_W-1:0] req_wdata,
  input  logic                 wb_ack,
  input  logic [WB_DATA_W-1:0] wb_dat_r,
  output logic                 wb_cyc,
  output logic                 wb_stb,
  output logic                 wb_we,
  output logic [ADDR_W-1:0]    wb_adr,
  output logic [WB_DATA_W-1:0] wb_dat_w,
  output logic                 busy,
  output logic                 rd_valid,
  output logic [WB_DATA_W-1:0] rd_data
);

  wb_state_e state;

  assign busy = (state != WB_IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= WB_IDLE;
      wb_cyc   <= 1'b0;
      wb_stb   <= 1'b0;
      wb_we    <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= 1'b0;
      case (state)
        WB_IDLE: if (req) begin
          wb_cyc <= 1'b1;
          wb_stb <= 1'b1;
          wb_we  <= req_we;
          state  <= WB_BUS;
        end
        WB_BUS: if (wb_ack) begin
          wb_cyc   <= 1'b0;
          wb_stb   <= 1'b0;
          rd_valid <= ~wb_we;
          state    <= WB_IDLE;
        end
        default: state <= WB_IDLE;
      endcase
    end
  end

  // address and data stay put from the request until ack.
  always_ff @(posedge clk) begin
    if (req && !busy) begin
      wb_adr   <= req_addr;
      wb_dat_w <= req_wdata;
    end
    if (busy && wb_ack && !wb_we) rd_data <= wb_dat_r;
  end

endmodule

// ==== design/wb_reg_bank.sv ====
`timescale 1ns/1ps

module wb_reg_bank
  import wb_pkg::*;
#(
  parameter int ADDR_W = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  logic [ADDR_W-1:0]    wb_adr,
  input  logic [WB_DATA_W-1:0] wb_dat_w,
  output logic [WB_DATA_W-1:0] wb_dat_r,
  output logic                 wb_ack
);

  localparam int DEPTH = 2 ** ADDR_W;

  logic [WB_DATA_W-1:0] regs [DEPTH];
  logic                 access;

  // the master still holds stb in the cycle after ack, so that cycle is skipped.
  assign access = wb_cyc & wb_stb & ~wb_ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) regs[i] <= '0;
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= access;
      if (access && wb_we) regs[wb_adr] <= wb_dat_w;
    end
  end

  always_ff @(posedge clk) begin
    if (access) wb_dat_r <= regs[wb_adr];
  end

endmodule

// ==== design/spi_reply.sv ====
`timescale 1ns/1ps

module spi_reply
  import spi_pkg::*;
  import wb_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  frame_start,
  input  logic                  rd_valid,
  input  logic                  status_req,
  input  logic                  bad_cmd,
  input  logic [WB_DATA_W-1:0]  rd_data,
  output logic [SPI_BYTE_W-1:0] reply_byte
);

  logic [SPI_BYTE_W-1:0] err_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_cnt    <= '0;
      reply_byte <= '0;
    end else begin
      if (bad_cmd && err_cnt != '1) err_cnt <= err_cnt + 1'b1; // saturates at 255.
      if (frame_start) reply_byte <= '0;
      else if (rd_valid) reply_byte <= rd_data;
      else if (status_req) reply_byte <= err_cnt;
    end
  end

endmodule

// ==== design/spi_bridge_top.sv ====
`timescale 1ns/1ps

module spi_bridge_top
  import spi_pkg::*;
  import wb_pkg::*;
#(
  parameter int ADDR_W = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic sck,
  input  logic mosi,
  input  logic ssel_n,
  output logic miso,
  output logic miso_en
);

  // ********************
  // frame side
  // ********************

  logic                  cmd_valid;
  logic                  param_valid;
  logic                  frame_start;
  logic                  frame_end;
  logic [SPI_BYTE_W-1:0] rx_byte;
  logic [SPI_BYTE_W-1:0] reply_byte;
  logic                  bad_cmd;
  logic                  status_req;

  // ********************
  // bus side
  // ********************

  logic                  req;
  logic                  req_we;
  logic [ADDR_W-1:0]     req_addr;
  logic [SPI_BYTE_W-1:0] req_wdata;
  logic                  busy;
  logic                  rd_valid;
  logic [WB_DATA_W-1:0]  rd_data;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic                  wb_ack;
  logic [ADDR_W-1:0]     wb_adr;
  logic [WB_DATA_W-1:0]  wb_dat_w;
  logic [WB_DATA_W-1:0]  wb_dat_r;

  spi_slave_rx u_rx (
    .clk         (clk),
    .rst_n       (rst_n),
    .sck         (sck),
    .mosi        (mosi),
    .ssel_n      (ssel_n),
    .reply_byte  (reply_byte),
    .miso        (miso),
    .miso_en     (miso_en),
    .cmd_valid   (cmd_valid),
    .param_valid (param_valid),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .rx_byte     (rx_byte)
  );

  spi_cmd_decoder #(.ADDR_W(ADDR_W)) u_dec (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .param_valid (param_valid),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .rx_byte     (rx_byte),
    .req         (req),
    .req_we      (req_we),
    .bad_cmd     (bad_cmd),
    .status_req  (status_req),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata)
  );

  wb_executor #(.ADDR_W(ADDR_W)) u_exec (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .req_we    (req_we),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .wb_ack    (wb_ack),
    .wb_dat_r  (wb_dat_r),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .busy      (busy),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data)
  );

  spi_reply u_reply (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_start (frame_start),
    .rd_valid    (rd_valid),
    .status_req  (status_req),
    .bad_cmd     (bad_cmd),
    .rd_data     (rd_data),
    .reply_byte  (reply_byte)
  );

  wb_reg_bank #(.ADDR_W(ADDR_W)) u_bank (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

endmodule

// ==== test/spi_bridge_asserts.sv ====
`timescale 1ns/1ps

module spi_bridge_asserts (
  input logic clk,
  input logic rst_n,
  input logic ssel_n,
  input logic miso_en,
  input logic cmd_valid,
  input logic param_valid,
  input logic req,
  input logic busy,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack
);

  stb_in_cycle: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
    else $error("wb_stb high outside a bus cycle");

  // the bank answers only a strobe that the master still holds.
  ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |-> wb_stb)
    else $error("wb_ack without wb_stb");

  one_strobe: assert property (@(posedge clk) disable iff (!rst_n) !(cmd_valid && param_valid))
    else $error("cmd_valid and param_valid high together");

  idle_miso_off: assert property (@(posedge clk) disable iff (!rst_n) ssel_n |-> !miso_en)
    else $error("miso_en high while the slave is deselected");

  // the sck rate leaves the executor idle before the next byte can ask for a bus cycle.
  req_when_idle: assert property (@(posedge clk) disable iff (!rst_n) req |-> !busy)
    else $error("req while the executor is still busy");

endmodule

bind spi_bridge_top spi_bridge_asserts u_asserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .ssel_n      (ssel_n),
  .miso_en     (miso_en),
  .cmd_valid   (cmd_valid),
  .param_valid (param_valid),
  .req         (req),
  .busy        (busy),
  .wb_cyc      (wb_cyc),
  .wb_stb      (wb_stb),
  .wb_ack      (wb_ack)
);

// ==== test/spi_bridge_checker.sv ====
`timescale 1ns/1ps

module spi_bridge_checker #(
  parameter int MAX_BYTES = 6
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   sck,
  input  logic                   mosi,
  input  logic                   ssel_n,
  input  logic                   miso,
  input  logic                   miso_en,
  input  logic [8*MAX_BYTES-1:0] exp_bytes,
  input  logic [7:0]             test_id,
  output int                     checked,
  output int                     failed,
  output int                     errors
);

  logic                   sck_q;
  logic                   ssel_q;
  logic                   miso_q;
  logic                   mosi_q;
  logic [7:0]             miso_sh;
  logic [7:0]             mosi_sh;
  logic [7:0]             exp_b;
  logic [8*MAX_BYTES-1:0] cur_exp;
  logic [7:0]             cur_id;
  int                     bit_n;
  int                     byte_n;
  int                     frame_err;

  // a bit is taken from the clk edge just before the sck rise, where miso has settled.
  always @(posedge clk) begin
    if (!rst_n) begin
      sck_q     = 1'b0;
      ssel_q    = 1'b1;
      miso_q    = 1'b0;
      mosi_q    = 1'b0;
      bit_n     = 0;
      byte_n    = 0;
      frame_err = 0;
      checked   = 0;
      failed    = 0;
      errors    = 0;
    end else begin
      if (miso_en !== !ssel_n) begin
        $display("ERROR miso_en: got 0x%h expected 0x%h", miso_en, !ssel_n);
        errors = errors + 1;
      end
      if (ssel_q && !ssel_n) begin // a frame opens.
        cur_exp   = exp_bytes;
        cur_id    = test_id;
        bit_n     = 0;
        byte_n    = 0;
        frame_err = 0;
      end
      if (!ssel_n && sck && !sck_q) begin
        miso_sh = {miso_sh[6:0], miso_q};
        mosi_sh = {mosi_sh[6:0], mosi_q};
        if (bit_n == 7 && byte_n < MAX_BYTES) begin
          exp_b = cur_exp[8*byte_n +: 8];
          if (exp_b != 8'hff && miso_sh !== exp_b) begin
            $display("ERROR miso: test %0d byte %0d (mosi 0x%h) got 0x%h expected 0x%h",
                     cur_id, byte_n, mosi_sh, miso_sh, exp_b);
            frame_err = frame_err + 1;
          end
        end
        if (bit_n == 7) begin
          byte_n = byte_n + 1;
          bit_n  = 0;
        end else begin
          bit_n = bit_n + 1;
        end
      end
      if (!ssel_q && ssel_n) begin // the frame closes.
        if (frame_err == 0) begin
          $display("test %0d: pass", cur_id);
        end else begin
          $display("test %0d: FAIL with %0d mismatches", cur_id, frame_err);
          failed = failed + 1;
        end
        checked = checked + 1;
      end
      sck_q  = sck;
      ssel_q = ssel_n;
      miso_q = miso;
      mosi_q = mosi;
    end
  end

endmodule

// ==== test/tb_spi_bridge.sv ====
`timescale 1ns/1ps

module tb_spi_bridge;

  localparam int NUM_TESTS = 18;
  localparam int MAX_BYTES = 6;
  localparam int LINE_W    = 2 + 2 * MAX_BYTES; // id, length, mosi bytes, miso bytes.
  localparam int HALF_SCK  = 24;                // clk cycles per sck half period.
  localparam int WAIT_MAX  = 200;

  logic                   clk;
  logic                   rst_n;
  logic                   sck;
  logic                   mosi;
  logic                   ssel_n;
  logic                   miso;
  logic                   miso_en;
  logic [7:0]             pat [NUM_TESTS * LINE_W];
  logic [8*MAX_BYTES-1:0] exp_bytes;
  logic [7:0]             exp_len;
  logic [7:0]             test_id;
  int                     checked;
  int                     failed;
  int                     errors;
  integer                 seed;
  bit                     timed_out;

  spi_bridge_top #(.ADDR_W(4)) dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .sck     (sck),
    .mosi    (mosi),
    .ssel_n  (ssel_n),
    .miso    (miso),
    .miso_en (miso_en)
  );

  spi_bridge_checker #(.MAX_BYTES(MAX_BYTES)) u_check (
    .clk       (clk),
    .rst_n     (rst_n),
    .sck       (sck),
    .mosi      (mosi),
    .ssel_n    (ssel_n),
    .miso      (miso),
    .miso_en   (miso_en),
    .exp_bytes (exp_bytes),
    .test_id   (test_id),
    .checked   (checked),
    .failed    (failed),
    .errors    (errors)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ********************
  // SPI host
  // ********************

  // mode 0, MSB first. mosi changes while sck is low.
  task automatic shift_byte(input logic [7:0] value);
    for (int i = 7; i >= 0; i--) begin
      mosi = value[i];
      repeat (HALF_SCK) @(negedge clk);
      sck = 1'b1;
      repeat (HALF_SCK) @(negedge clk);
      sck = 1'b0;
    end
  endtask

  task automatic run_frame(input int t);
    int base;
    int gap;
    int waited;
    base    = t * LINE_W;
    test_id = pat[base];
    exp_len = pat[base + 1];
    for (int i = 0; i < MAX_BYTES; i++) begin
      exp_bytes[8*i +: 8] = pat[base + 2 + MAX_BYTES + i];
    end
    gap = 4 + int'($unsigned($random(seed)) % 28);
    repeat (gap) @(negedge clk);
    ssel_n = 1'b0;
    for (int i = 0; i < int'(exp_len); i++) begin
      shift_byte(pat[base + 2 + i]);
    end
    repeat (HALF_SCK) @(negedge clk);
    ssel_n = 1'b1;
    mosi   = 1'b0;
    waited = 0;
    while (checked == t && waited < WAIT_MAX) begin
      @(negedge clk);
      waited++;
    end
    if (checked == t) begin
      $display("test %0d: the checker gave no result within %0d cycles after the frame",
               test_id, WAIT_MAX);
      timed_out = 1'b1;
    end
  endtask

  // ********************
  // main sequence
  // ********************

  initial begin
    seed      = 32'hc7b3_c448;
    rst_n     = 1'b0;
    sck       = 1'b0;
    mosi      = 1'b0;
    ssel_n    = 1'b1;
    exp_bytes = '0;
    exp_len   = '0;
    test_id   = '0;
    timed_out = 1'b0;
    $readmemh("test/spi_patterns.txt", pat);
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
      run_frame(t);
    end
    repeat (8) @(negedge clk);
    $display("tests checked %0d of %0d, failed %0d, other errors %0d",
             checked, NUM_TESTS, failed, errors);
    if (!timed_out && checked == NUM_TESTS && failed == 0 && errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== test/spi_patterns.txt ====
// id len | mosi bytes 0..5, padded with 00 | expected miso bytes 0..5, ff is not checked
// opcodes: 01 write, 02 read, 03 write_inc, 05 status, any other value is unknown
01 03  02 00 ff 00 00 00  00 00 00 ff ff ff
02 03  02 0f ff 00 00 00  00 00 00 ff ff ff
03 03  01 05 3c 00 00 00  00 00 00 ff ff ff
04 03  02 05 ff 00 00 00  00 00 3c ff ff ff
05 03  01 a9 c7 00 00 00  00 00 00 ff ff ff
06 03  02 09 ff 00 00 00  00 00 c7 ff ff ff
07 06  03 0e 11 22 33 44  00 00 00 00 00 00
08 03  02 0e ff 00 00 00  00 00 11 ff ff ff
09 03  02 0f ff 00 00 00  00 00 22 ff ff ff
0a 03  02 00 ff 00 00 00  00 00 33 ff ff ff
0b 03  02 01 ff 00 00 00  00 00 44 ff ff ff
0c 03  a5 01 55 00 00 00  00 00 00 ff ff ff
0d 03  02 f1 ff 00 00 00  00 00 44 ff ff ff
0e 02  05 ff 00 00 00 00  00 01 ff ff ff ff
0f 03  00 0e 99 00 00 00  00 00 00 ff ff ff
10 03  05 ff ff 00 00 00  00 02 02 ff ff ff
11 02  02 0e 00 00 00 00  00 00 ff ff ff ff
12 03  02 05 ff 00 00 00  00 00 3c ff ff ff

// ==== list.f ====
design/spi_pkg.sv
design/wb_pkg.sv
design/spi_slave_rx.sv
design/spi_cmd_decoder.sv
design/wb_executor.sv
design/wb_reg_bank.sv
design/spi_reply.sv
design/spi_bridge_top.sv
test/spi_bridge_asserts.sv
test/spi_bridge_checker.sv
test/tb_spi_bridge.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_spi_bridge -f list.f -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"
echo "$out" | grep -q "Regression passed"
